// ==== tb/acc_patterns.mem ====
// columns: reset-before flag (f ends the list), instruction {opcode, imm},
// expected accumulator, expected error bit
0 000 00 0
0 1a5 a5 0
0 26b 10 0
0 320 f0 0
0 400 0f 0
0 1c3 c3 0
0 5f0 c0 0
0 60a ca 0
0 7ff 35 0
0 800 6a 0
0 800 d4 0
0 800 a8 0
0 900 54 0
0 1ff ff 0
0 201 00 0
0 301 ff 0
0 900 7f 0
0 000 7f 0
0 a12 00 1
0 155 00 1
0 233 00 1
0 f00 00 1
1 200 00 0
0 13c 3c 0
0 2c4 00 0
0 30a f6 0
0 b00 00 1
0 000 00 1
1 305 fb 0
0 7a5 5e 0
0 6a1 ff 0
0 500 00 0
0 199 99 0
1 0ff 00 0
0 e77 00 1
1 142 42 0
0 8ff 84 0
f 000 00 0

// ==== project.f ====
hdl/alu_isa_pkg.sv
hdl/acc_stream_pkg.sv
hdl/acc_alu.sv
hdl/issue_ctrl.sv
hdl/acc_unit_top.sv
tb/acc_unit_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the accumulator unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=acc_unit_sim
LOG_FILE=sim.log

verilator --binary --timing --assert \
   -Mdir "$BUILD_DIR" \
   --top-module acc_unit_tb \
   -o "$SIM_BIN" \
   -f project.f
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
run_status=$?
cat "$LOG_FILE"
if [ $run_status -ne 0 ]; then
   echo "simulation exited with status $run_status"
   exit 1
fi

if grep -q "Simulation failed" "$LOG_FILE"; then
   exit 1
fi
exit 0

// ==== tb/acc_unit_tb.sv ====
`timescale 1ns/1ns

module acc_unit_tb;

   import alu_isa_pkg::*;
   import acc_stream_pkg::*;

   localparam int MAX_PATTERNS = 64;
   localparam int CLOCK_HALF = 10;

   logic        clock;
   logic        reset;
   logic        in_valid;
   logic        in_ready;
   inst_t       in_inst;
   logic        out_valid;
   logic        out_ready;
   acc_result_t out_result;

   logic [11:0] pat_mem [0:4*MAX_PATTERNS-1];   // four words per pattern line
   logic        pat_flag [0:MAX_PATTERNS-1];
   logic [11:0] pat_inst [0:MAX_PATTERNS-1];
   logic [7:0]  exp_acc [0:MAX_PATTERNS-1];
   logic        exp_err [0:MAX_PATTERNS-1];
   logic [7:0]  exp_seq [0:MAX_PATTERNS-1];

   int          n_patterns = 0;
   int          rx_count = 0;
   int          check_count = 0;
   int          value_errors = 0;
   int          other_errors = 0;
   logic        loaded = 1'b0;
   logic        stalled = 1'b0;
   acc_result_t held_result;

   acc_unit_top u_dut (
      .clock      (clock),
      .reset      (reset),
      .in_valid   (in_valid),
      .in_ready   (in_ready),
      .in_inst    (in_inst),
      .out_valid  (out_valid),
      .out_ready  (out_ready),
      .out_result (out_result)
   );

   initial clock = 1'b0;
   always #CLOCK_HALF clock = ~clock;

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      check_count++;
      if (expected !== actual) begin
         $display("ERR %s expected %0h actual %0h", name, expected, actual);
         value_errors++;
      end
   endtask

   task automatic check_record(input int idx);
      check_value($sformatf("pattern %0d accum", idx), {24'd0, exp_acc[idx]},
                  {24'd0, out_result.accum});
      check_value($sformatf("pattern %0d error", idx), {31'd0, exp_err[idx]},
                  {31'd0, out_result.error});
      check_value($sformatf("pattern %0d seq", idx), {24'd0, exp_seq[idx]},
                  {24'd0, out_result.seq});
   endtask

   task automatic load_patterns();
      logic [7:0] tag;
      $readmemh("tb/acc_patterns.mem", pat_mem);
      tag = 8'd0;
      n_patterns = 0;
      while (n_patterns < MAX_PATTERNS && pat_mem[4*n_patterns] !== 12'hf) begin
         pat_flag[n_patterns] = pat_mem[4*n_patterns][0];
         pat_inst[n_patterns] = pat_mem[4*n_patterns+1];
         exp_acc[n_patterns]  = pat_mem[4*n_patterns+2][7:0];
         exp_err[n_patterns]  = pat_mem[4*n_patterns+3][0];
         if (pat_flag[n_patterns]) begin
            tag = 8'd0;   // tag restarts after reset
         end
         exp_seq[n_patterns] = tag;
         tag = tag + 8'd1;
         n_patterns++;
      end
      if (n_patterns == 0 || n_patterns == MAX_PATTERNS) begin
         $display("pattern file is missing, empty or has no end marker");
         other_errors++;
         n_patterns = 0;
      end
   endtask

   task automatic apply_reset();
      reset = 1'b1;
      repeat (4) @(posedge clock);
      #2;
      reset = 1'b0;
   endtask

   task automatic send_inst(input logic [11:0] inst);
      logic taken;
      in_valid = 1'b1;
      in_inst  = inst_t'(inst);
      taken = 1'b0;
      while (!taken) begin
         @(negedge clock);
         taken = in_ready;   // transfer on the coming edge
         @(posedge clock);
         #2;
      end
      in_valid = 1'b0;
   endtask

   task automatic idle_gap();
      int unsigned gap;
      gap = $urandom % 4;
      repeat (gap) begin
         @(posedge clock);
         #2;
      end
   endtask

   task automatic drain_outputs(input int count);
      while (rx_count < count) begin
         @(posedge clock);
         #2;
      end
   endtask

   initial begin : main
      reset    = 1'b1;
      in_valid = 1'b0;
      in_inst  = inst_t'(12'h000);
      void'($urandom(32'h7ff2));
      load_patterns();
      loaded = 1'b1;
      if (n_patterns > 0) begin
         apply_reset();
         for (int i = 0; i < n_patterns; i++) begin
            if (pat_flag[i]) begin
               drain_outputs(i);
               apply_reset();
            end
            send_inst(pat_inst[i]);
            idle_gap();
         end
         drain_outputs(n_patterns);
         repeat (4) @(posedge clock);   // catch stray records
      end
      $display("checks %0d, value errors %0d, other errors %0d",
               check_count, value_errors, other_errors);
      if (value_errors == 0 && other_errors == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

   initial begin : monitor
      out_ready = 1'b0;
      wait (loaded);
      forever begin
         @(posedge clock);
         #2;
         out_ready = (($urandom % 100) < 70);
         @(negedge clock);
         if (stalled && out_valid) begin
            check_value("stall hold", {15'd0, held_result}, {15'd0, out_result});
         end
         if (out_valid && !out_ready) begin
            check_value("stall in_ready", 32'd0, {31'd0, in_ready});
            held_result = out_result;
            stalled = 1'b1;
         end else begin
            stalled = 1'b0;
         end
         if (out_valid && out_ready) begin
            if (rx_count >= n_patterns) begin
               $display("unexpected record after the last pattern, seq %0d", out_result.seq);
               other_errors++;
            end else begin
               check_record(rx_count);
            end
            rx_count++;
         end
      end
   end

   initial begin : watchdog
      int limit;
      wait (loaded);
      limit = n_patterns * 40 + 200;
      repeat (limit) @(posedge clock);
      $display("timeout: only %0d of %0d records came out within %0d cycles",
               rx_count, n_patterns, limit);
      $display("Simulation failed");
      $finish;
   end

endmodule

// ==== hdl/acc_unit_top.sv ====
`timescale 1ns/1ns

module acc_unit_top #(
   parameter int SEQ_WIDTH = 8
) (
   input  logic                        clock,
   input  logic                        reset,
   input  logic                        in_valid,
   output logic                        in_ready,
   input  alu_isa_pkg::inst_t          in_inst,
   output logic                        out_valid,
   input  logic                        out_ready,
   output acc_stream_pkg::acc_result_t out_result
);

   import alu_isa_pkg::*;

   logic                 inst_en;
   logic [ACC_WIDTH-1:0] alu_accum;
   alu_state_t           alu_state;

   issue_ctrl #(
      .SEQ_WIDTH (SEQ_WIDTH)
   ) u_issue (
      .clock      (clock),
      .reset      (reset),
      .in_valid   (in_valid),
      .in_ready   (in_ready),
      .inst_en    (inst_en),
      .alu_state  (alu_state),
      .alu_accum  (alu_accum),
      .out_valid  (out_valid),
      .out_ready  (out_ready),
      .out_result (out_result)
   );

   // instruction goes straight from the input port
   acc_alu u_alu (
      .clock   (clock),
      .reset   (reset),
      .inst    (in_inst),
      .inst_en (inst_en),
      .accum   (alu_accum),
      .state   (alu_state)
   );

endmodule

// ==== hdl/issue_ctrl.sv ====
`timescale 1ns/1ns

module issue_ctrl #(
   parameter int SEQ_WIDTH = 8
) (
   input  logic                              clock,
   input  logic                              reset,
   input  logic                              in_valid,
   output logic                              in_ready,
   output logic                              inst_en,
   input  alu_isa_pkg::alu_state_t           alu_state,
   input  logic [alu_isa_pkg::ACC_WIDTH-1:0] alu_accum,
   output logic                              out_valid,
   input  logic                              out_ready,
   output acc_stream_pkg::acc_result_t       out_result
);

   import alu_isa_pkg::*;
   import acc_stream_pkg::*;

   logic                 out_valid_q;
   logic [SEQ_WIDTH-1:0] seq_count;   // tag of the next accepted instruction
   logic [SEQ_WIDTH-1:0] seq_out;     // tag of the record in the output
   logic                 out_free;

   if (SEQ_WIDTH < 1 || SEQ_WIDTH > SEQ_WIDTH_DEF) begin : g_width_check
      $error("SEQ_WIDTH must be between 1 and %0d", SEQ_WIDTH_DEF);
   end

   // output slot empties on this edge, or is already empty
   assign out_free = !out_valid_q || out_ready;

   assign in_ready  = (alu_state != st_reset) && out_free;
   assign inst_en   = in_valid && in_ready;
   assign out_valid = out_valid_q;

   always_ff @(posedge clock) begin
      if (reset) begin
         out_valid_q <= 1'b0;
      end else if (inst_en) begin
         out_valid_q <= 1'b1;   // new record replaces any leaving one
      end else if (out_ready) begin
         out_valid_q <= 1'b0;
      end
   end

   always_ff @(posedge clock) begin
      if (reset) begin
         seq_count <= '0;
      end else if (inst_en) begin
         seq_count <= seq_count + 1'b1;   // wraps
      end
   end

   always_ff @(posedge clock) begin
      if (inst_en) begin
         seq_out <= seq_count;
      end
   end

   // record fields follow the ALU registers, updated on the same edge
   assign out_result.error = (alu_state == st_error);
   assign out_result.accum = alu_accum;
   assign out_result.seq   = SEQ_WIDTH_DEF'(seq_out);

   // stalled record and the ALU outputs must not move
   a_hold_on_stall: assert property (@(posedge clock) disable iff (reset)
      out_valid && !out_ready |=> out_valid && $stable(out_result));

endmodule

// ==== hdl/acc_alu.sv ====
`timescale 1ns/1ns

module acc_alu (
   input  logic                              clock,
   input  logic                              reset,
   input  alu_isa_pkg::inst_t                inst,
   input  logic                              inst_en,
   output logic [alu_isa_pkg::ACC_WIDTH-1:0] accum,
   output alu_isa_pkg::alu_state_t           state
);

   import alu_isa_pkg::*;

   logic [ACC_WIDTH-1:0] accum_q;
   logic [ACC_WIDTH-1:0] accum_d;
   alu_state_t           state_q;
   alu_state_t           state_d;
   logic [ACC_WIDTH-1:0] imm;
   logic                 op_valid;
   logic [ACC_WIDTH-1:0] op_result;

   assign imm   = inst.imm;
   assign accum = accum_q;
   assign state = state_q;

   // operation of the presented opcode on the current accumulator
   always_comb begin
      op_valid  = 1'b1;
      op_result = accum_q;
      case (inst.opcode)
         op_nop: begin
            op_result = accum_q;
         end
         op_ldi: begin
            op_result = imm;
         end
         op_add: begin
            op_result = accum_q + imm;   // wraps at 8 bits
         end
         op_sub: begin
            op_result = accum_q - imm;
         end
         op_not: begin
            op_result = ~accum_q;
         end
         op_and: begin
            op_result = accum_q & imm;
         end
         op_ior: begin
            op_result = accum_q | imm;
         end
         op_xor: begin
            op_result = accum_q ^ imm;
         end
         op_shl: begin
            op_result = {accum_q[ACC_WIDTH-2:0], 1'b0};
         end
         op_shr: begin
            op_result = {1'b0, accum_q[ACC_WIDTH-1:1]};
         end
         default: begin
            op_valid  = 1'b0;   // undefined opcode
            op_result = '0;
         end
      endcase
   end

   always_comb begin
      state_d = state_q;
      accum_d = accum_q;
      case (state_q)
         st_reset: begin
            state_d = st_ready;   // single settle cycle
            accum_d = '0;
         end
         st_ready: begin
            if (inst_en) begin
               accum_d = op_result;
               if (!op_valid) begin
                  state_d = st_error;
               end
            end
         end
         st_error: begin
            accum_d = '0;   // instructions ignored
         end
         default: begin
            state_d = st_error;
            accum_d = '0;
         end
      endcase
   end

   always_ff @(posedge clock) begin
      if (reset) begin
         state_q <= st_reset;
         accum_q <= '0;
      end else begin
         state_q <= state_d;
         accum_q <= accum_d;
      end
   end

   // issue controller must hold off while the unit settles
   a_no_issue_in_reset: assert property (@(posedge clock) disable iff (reset)
      !(inst_en && state_q == st_reset));

   a_state_legal: assert property (@(posedge clock) disable iff (reset)
      state_q inside {st_reset, st_ready, st_error});

endmodule

// ==== hdl/acc_stream_pkg.sv ====
package acc_stream_pkg;

   // narrower counters are zero extended to this tag width
   parameter int SEQ_WIDTH_DEF = 8;

   typedef struct packed {
      logic                                error;   // unit in error state
      logic [alu_isa_pkg::ACC_WIDTH-1:0]   accum;
      logic [SEQ_WIDTH_DEF-1:0]            seq;     // accepted instruction number
   } acc_result_t;

endpackage

// ==== hdl/alu_isa_pkg.sv ====
package alu_isa_pkg;

   // accumulator follows the immediate field width
   parameter int ACC_WIDTH = 8;

   typedef enum logic [3:0] {
      op_nop = 4'h0,
      op_ldi = 4'h1,
      op_add = 4'h2,
      op_sub = 4'h3,
      op_not = 4'h4,
      op_and = 4'h5,
      op_ior = 4'h6,
      op_xor = 4'h7,
      op_shl = 4'h8,   // shift left by one
      op_shr = 4'h9    // shift right by one, zero fill
   } opcode_t;         // 4'ha to 4'hf undefined

   typedef struct packed {
      opcode_t              opcode;
      logic [ACC_WIDTH-1:0] imm;
   } inst_t;

   typedef enum logic [1:0] {
      st_reset = 2'h0,
      st_ready = 2'h1,
      st_error = 2'h2   // sticky until reset
   } alu_state_t;

endpackage
